//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_dct_top
FILELIST  = dct_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dct_cos_rom.sv
`timescale 1ns/100ps

module dct_cos_rom
    import dct_pkg::*;
(
    input  logic                         Clock,
    input  logic [$clog2(COS_TERMS)-1:0] angle,    // units of pi/32
    output logic signed [NBITS-1:0]      cos_val
);

    logic [$clog2(COS_TERMS)-1:0] folded;       // angle mirrored into 0..pi
    logic [$clog2(COS_TERMS)-2:0] quarter_idx;  // 0..16 covers 0..pi/2
    logic                         negate;
    logic signed [NBITS-1:0]      quarter_val;

    always_comb begin
        if (angle > COS_TERMS / 2)
            folded = 6'(COS_TERMS - angle);  // cos(2pi - x) = cos(x)
        else
            folded = angle;

        if (folded > COS_TERMS / 4) begin
            quarter_idx = 5'(COS_TERMS / 2 - folded);  // cos(pi - x) = -cos(x)
            negate      = 1'b1;
        end else begin
            quarter_idx = 5'(folded);
            negate      = 1'b0;
        end
    end

    // Q15 of cos(pi*i/32), 1.0 clipped to the largest positive code
    always_comb begin
        case (quarter_idx)
            5'd0:    quarter_val = 16'sd32767;
            5'd1:    quarter_val = 16'sd32610;
            5'd2:    quarter_val = 16'sd32138;
            5'd3:    quarter_val = 16'sd31357;
            5'd4:    quarter_val = 16'sd30274;
            5'd5:    quarter_val = 16'sd28899;
            5'd6:    quarter_val = 16'sd27246;
            5'd7:    quarter_val = 16'sd25330;
            5'd8:    quarter_val = 16'sd23170;
            5'd9:    quarter_val = 16'sd20788;
            5'd10:   quarter_val = 16'sd18205;
            5'd11:   quarter_val = 16'sd15447;
            5'd12:   quarter_val = 16'sd12540;
            5'd13:   quarter_val = 16'sd9512;
            5'd14:   quarter_val = 16'sd6393;
            5'd15:   quarter_val = 16'sd3212;
            default: quarter_val = 16'sd0;  // pi/2
        endcase
    end

    always_ff @(posedge Clock) begin
        cos_val <= negate ? -quarter_val : quarter_val;  // one cycle lookup
    end

endmodule

//--- dct_engine.sv
`timescale 1ns/100ps

module dct_engine
    import dct_pkg::*;
(
    input  logic                         Clock,
    input  logic                         Reset,
    input  sample_wr_t                   sample_wr,
    input  logic                         start,
    input  logic [2:0]                   size_pow,
    output logic [$clog2(COS_TERMS)-1:0] angle,
    input  logic signed [NBITS-1:0]      cos_val,
    output res_wr_t                      wr,
    input  logic                         wr_ack,
    output logic                         busy
);

    eng_state_e state;

    logic signed [NBITS-1:0]          samples [MAX_SIZE];
    logic [2:0]                       pow;
    logic [IDX_W-1:0]                 last;    // size - 1
    logic [IDX_W-1:0]                 k;       // coefficient being built
    logic [IDX_W-1:0]                 n;       // index of the next lookup
    logic [IDX_W-1:0]                 mac_n;   // index matching cos_val
    logic [2*IDX_W-1:0]               nk;
    logic [2*IDX_W+MAX_POWER-1:0]     phase;
    logic signed [2*NBITS-1:0]        product;
    logic signed [ACC_W-1:0]          acc;
    logic signed [ACC_W-1:0]          total;
    logic signed [NBITS-1:0]          coef;
    logic signed [NBITS-1:0]          coef_next;

    assign last = IDX_W'((1 << pow) - 1);

    // angle = n*k*32/size modulo one period
    assign nk    = n * k;
    assign phase = {nk, {MAX_POWER{1'b0}}} >> pow;
    assign angle = phase[$clog2(COS_TERMS)-1:0];

    assign product = samples[mac_n] * cos_val;

    always_ff @(posedge Clock) begin
        if (sample_wr.valid)
            samples[sample_wr.idx] <= sample_wr.data;
    end

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            state <= IDLE;
            pow   <= '0;
            k     <= '0;
            n     <= '0;
            mac_n <= '0;
        end else if (start) begin
            pow   <= size_pow;
            k     <= '0;
            n     <= '0;
            state <= LOAD;
        end else begin
            case (state)
                LOAD: begin
                    n     <= n + 1'b1;
                    mac_n <= '0;
                    state <= MAC;
                end
                MAC: begin
                    n     <= n + 1'b1;
                    mac_n <= mac_n + 1'b1;
                    if (mac_n == last)
                        state <= FINISH;
                end
                FINISH: state <= WRITE;
                WRITE: begin
                    if (wr_ack) begin
                        if (k == last) begin
                            state <= IDLE;
                        end else begin
                            k     <= k + 1'b1;
                            n     <= '0;
                            state <= LOAD;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // end samples are added separately as halves
    always_ff @(posedge Clock) begin
        if (state == LOAD)
            acc <= '0;
        else if (state == MAC && mac_n != '0 && mac_n != last)
            acc <= acc + ACC_W'(product);
        if (state == FINISH)
            coef <= coef_next;
    end

    always_comb begin
        total = (acc >>> (NBITS - 1)) + ACC_W'(samples[0] >>> 1);
        if (k[0])
            total = total - ACC_W'(samples[last] >>> 1);  // (-1)^k on the last sample
        else
            total = total + ACC_W'(samples[last] >>> 1);
        if (&total[ACC_W-1:NBITS-1] || ~|total[ACC_W-1:NBITS-1])
            coef_next = total[NBITS-1:0];
        else if (total[ACC_W-1])
            coef_next = {1'b1, {(NBITS - 1){1'b0}}};  // clip negative
        else
            coef_next = {1'b0, {(NBITS - 1){1'b1}}};
    end

    assign wr   = '{req: (state == WRITE), idx: k, data: coef};
    assign busy = (state != IDLE);

    a_wr_idx: assert property (@(posedge Clock) disable iff (Reset)
        wr.req |-> (6'(wr.idx) < (6'd1 << pow)))
        else $error("engine write index %0d beyond transform size", wr.idx);

endmodule

//--- dct_host_regs.sv
`timescale 1ns/100ps

module dct_host_regs
    import dct_pkg::*;
(
    input  logic             Clock,
    input  logic             Reset,
    input  logic [7:0]       address,
    input  logic             read,
    input  logic             write,
    input  logic [NBITS-1:0] writedata,
    output sample_wr_t       sample_wr,
    output logic             start,
    output logic             clear_valid,
    output logic [2:0]       size_pow,
    output res_rd_t          rd,
    input  res_rsp_t         rsp,
    output logic [NBITS-1:0] readdata,
    output logic             stall
);

    addr_e            addr;
    logic [IDX_W:0]   size;       // 0 until the first start write
    logic [IDX_W-1:0] load_idx;
    logic             loading;    // accepting samples
    logic             start_wr;
    logic             data_wr;
    logic             in_range;
    logic             got;        // current read already answered
    logic             pending;
    logic [NBITS-1:0] held;

    assign addr     = addr_e'(address);
    assign size     = (size_pow == 3'd0) ? '0 : (IDX_W + 1)'(1) << size_pow;
    assign start_wr = write && (addr == ADDR_START) &&
                      (writedata >= 1) && (writedata <= MAX_POWER);
    assign data_wr  = write && (addr == ADDR_DATA) && loading;

    // samples go straight to the engine buffer
    assign sample_wr = '{valid: data_wr, idx: load_idx, data: writedata};

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            size_pow    <= '0;
            load_idx    <= '0;
            loading     <= 1'b0;
            start       <= 1'b0;
            clear_valid <= 1'b0;
        end else begin
            start       <= 1'b0;
            clear_valid <= start_wr;  // store empties one edge later
            if (start_wr) begin
                size_pow <= writedata[2:0];
                load_idx <= '0;
                loading  <= 1'b1;
            end else if (data_wr) begin
                load_idx <= load_idx + 1'b1;
                if ({1'b0, load_idx} == size - 1'b1) begin
                    loading <= 1'b0;   // extra samples dropped until restart
                    start   <= 1'b1;
                end
            end
        end
    end

    // read side
    assign in_range = address < 8'(size);
    assign pending  = read && in_range && !got && !rsp.ack;
    assign rd       = '{req: pending, idx: address[IDX_W-1:0]};
    assign stall    = pending;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset)
            got <= 1'b0;
        else if (!read)
            got <= 1'b0;
        else if (rsp.ack)
            got <= 1'b1;  // host may keep read high past the ack
    end

    always_ff @(posedge Clock) begin
        if (rsp.ack)
            held <= rsp.data;
    end

    always_comb begin
        if (read && in_range)
            readdata = rsp.ack ? rsp.data : held;
        else
            readdata = '0;  // out of range reads see zero
    end

    a_start_pulse: assert property (@(posedge Clock) disable iff (Reset)
        start |=> !start)
        else $error("start held for more than one cycle");

endmodule

//--- dct_pkg.sv
package dct_pkg;

    localparam int MAX_SIZE  = 32;   // points per transform
    localparam int MAX_POWER = 5;    // log2(MAX_SIZE)
    localparam int NBITS     = 16;   // Q1.15 sample and coefficient width
    localparam int COS_TERMS = 64;   // angles in one full cosine period
    localparam int IDX_W     = 5;    // point index width
    localparam int ACC_W     = 40;   // MAC accumulator width

    // host register map
    typedef enum logic [7:0] {
        ADDR_START = 8'd0,  // write power of two, restart loading
        ADDR_DATA  = 8'd1   // write next sample
    } addr_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,    // first cosine lookup in flight
        MAC,
        FINISH,
        WRITE
    } eng_state_e;

    // host sample write toward the engine
    typedef struct packed {
        logic             valid;
        logic [IDX_W-1:0] idx;
        logic [NBITS-1:0] data;
    } sample_wr_t;

    // engine write request into the result store
    typedef struct packed {
        logic             req;
        logic [IDX_W-1:0] idx;
        logic [NBITS-1:0] data;
    } res_wr_t;

    // host read request into the result store
    typedef struct packed {
        logic             req;
        logic [IDX_W-1:0] idx;
    } res_rd_t;

    typedef struct packed {
        logic             ack;
        logic [NBITS-1:0] data;
    } res_rsp_t;

endpackage

//--- dct_result_store.sv
`timescale 1ns/100ps

module dct_result_store
    import dct_pkg::*;
(
    input  logic     Clock,
    input  logic     Reset,
    input  logic     clear_valid,
    input  res_wr_t  wr,
    output logic     wr_ack,
    input  res_rd_t  rd,
    output res_rsp_t rsp
);

    logic [NBITS-1:0]    coef_mem [MAX_SIZE];
    logic [MAX_SIZE-1:0] valid;
    logic                rd_grant;
    logic                ack_q;
    logic [NBITS-1:0]    data_q;

    // a read of a missing entry takes no slot, so the engine can still fill it
    assign rd_grant = rd.req && valid[rd.idx];
    assign wr_ack   = wr.req && !rd_grant;  // host read wins

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            valid <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= rd_grant;
            if (clear_valid)
                valid <= '0;
            else if (wr_ack)
                valid[wr.idx] <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (wr_ack)
            coef_mem[wr.idx] <= wr.data;
        if (rd_grant)
            data_q <= coef_mem[rd.idx];
    end

    assign rsp = '{ack: ack_q, data: data_q};

    a_one_access: assert property (@(posedge Clock) disable iff (Reset)
        !(wr_ack && rd_grant))
        else $error("read and write granted together");

    // engine must hold its request steady until accepted
    a_wr_hold: assert property (@(posedge Clock) disable iff (Reset)
        wr.req && !wr_ack |=> wr.req && $stable(wr.idx) && $stable(wr.data))
        else $error("engine dropped or changed a pending write");

endmodule

//--- dct_top.f
dct_pkg.sv
dct_cos_rom.sv
dct_host_regs.sv
dct_engine.sv
dct_result_store.sv
dct_top.sv
tb_dct_top.sv

//--- dct_top.sv
`timescale 1ns/100ps

module dct_top
    import dct_pkg::*;
(
    input  logic             Clock,
    input  logic             Reset,
    input  logic [7:0]       address,
    input  logic             read,
    input  logic             write,
    input  logic [NBITS-1:0] writedata,
    output logic [NBITS-1:0] readdata,
    output logic             stall
);

    sample_wr_t                   sample_wr;
    logic                         start;
    logic                         clear_valid;
    logic [2:0]                   size_pow;
    res_rd_t                      rd;
    res_rsp_t                     rsp;
    logic [$clog2(COS_TERMS)-1:0] angle;
    logic signed [NBITS-1:0]      cos_val;
    res_wr_t                      wr;
    logic                         wr_ack;

    dct_host_regs u_host_regs (
        .Clock       (Clock),
        .Reset       (Reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .sample_wr   (sample_wr),
        .start       (start),
        .clear_valid (clear_valid),
        .size_pow    (size_pow),
        .rd          (rd),
        .rsp         (rsp),
        .readdata    (readdata),
        .stall       (stall)
    );

    dct_engine u_engine (
        .Clock     (Clock),
        .Reset     (Reset),
        .sample_wr (sample_wr),
        .start     (start),
        .size_pow  (size_pow),
        .angle     (angle),
        .cos_val   (cos_val),
        .wr        (wr),
        .wr_ack    (wr_ack),
        .busy      ()
    );

    dct_cos_rom u_cos_rom (
        .Clock   (Clock),
        .angle   (angle),
        .cos_val (cos_val)
    );

    dct_result_store u_result_store (
        .Clock       (Clock),
        .Reset       (Reset),
        .clear_valid (clear_valid),
        .wr          (wr),
        .wr_ack      (wr_ack),
        .rd          (rd),
        .rsp         (rsp)
    );

endmodule

//--- tb_dct_top.sv
`timescale 1ns/100ps

module tb_dct_top
    import dct_pkg::*;
();

    localparam int  TIMEOUT_CYCLES = 20000;  // five tests of at most 32 x 35 cycles, wide margin
    localparam real PI             = 3.14159265358979;

    logic             Clock;
    logic             Reset;
    logic [7:0]       address;
    logic             read;
    logic             write;
    logic [NBITS-1:0] writedata;
    logic [NBITS-1:0] readdata;
    logic             stall;

    int seed;
    int samples [MAX_SIZE];  // copy of what the host loaded
    int cur_size;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    dct_top u_dct_top (
        .Clock     (Clock),
        .Reset     (Reset),
        .address   (address),
        .read      (read),
        .write     (write),
        .writedata (writedata),
        .readdata  (readdata),
        .stall     (stall)
    );

    always #2 Clock = ~Clock;

    // half end samples, signed last term, cosine weighted middle
    function automatic real expected_coef(input int k);
        real sum;
        sum = samples[0] / 2.0;
        if (k % 2 == 0)
            sum = sum + samples[cur_size-1] / 2.0;
        else
            sum = sum - samples[cur_size-1] / 2.0;
        for (int n = 1; n <= cur_size - 2; n++)
            sum = sum + samples[n] * $cos(PI * n * k / cur_size);
        if (sum > 32767.0)
            sum = 32767.0;  // hardware clips to 16 bits
        else if (sum < -32768.0)
            sum = -32768.0;
        return sum;
    endfunction

    task automatic start_transform(input int power);
        @(posedge Clock);
        #1;
        address   = ADDR_START;
        writedata = 16'(power);
        write     = 1'b1;
        @(posedge Clock);
        #1;
        write    = 1'b0;
        cur_size = 1 << power;
    endtask

    task automatic write_sample(input int idx, input int value);
        samples[idx] = value;
        @(posedge Clock);
        #1;
        address   = ADDR_DATA;
        writedata = 16'(value);
        write     = 1'b1;
        @(posedge Clock);
        #1;
        write = 1'b0;
    endtask

    // stall is sampled on the falling edge, away from input changes
    task automatic read_coef(input int idx, output int value, output int waited);
        @(posedge Clock);
        #1;
        address = 8'(idx);
        read    = 1'b1;
        waited  = 0;
        @(negedge Clock);
        while (stall) begin
            waited++;
            @(negedge Clock);
        end
        value = $signed(readdata);
        @(posedge Clock);
        #1;
        read = 1'b0;
    endtask

    task automatic compare_coef(input int idx, input int value);
        real expected;
        real diff;
        expected = expected_coef(idx);
        diff     = value - expected;
        assert (diff <= cur_size + 2 && diff >= -(cur_size + 2)) else begin
            $display("error %0t: coefficient %0d read %0d expected %0.2f",
                     $time, idx, value, expected);
            test_errors++;
        end
    endtask

    task automatic expect_zero_read(input int idx);
        int value;
        int waited;
        read_coef(idx, value, waited);
        assert (value == 0) else begin
            $display("error %0t: read of index %0d gave %0d instead of 0", $time, idx, value);
            test_errors++;
        end
        assert (waited == 0) else begin
            $display("read of index %0d outside the transform stalled", idx);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s done, no errors", name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge Clock);
            cycle_count++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int value;
        int waited;
        Clock        = 1'b0;
        Reset        = 1'b1;
        address      = '0;
        read         = 1'b0;
        write        = 1'b0;
        writedata    = '0;
        seed         = 32'hdee7_4a13;
        cur_size     = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge Clock);
        #1;
        Reset = 1'b0;

        // size is still 0 after reset
        expect_zero_read(0);
        finish_test("reset_read");

        start_transform(3);
        for (int i = 0; i < cur_size; i++)
            write_sample(i, 16384);
        for (int i = 0; i < cur_size; i++) begin
            read_coef(i, value, waited);
            compare_coef(i, value);
        end
        finish_test("constant_size8");

        start_transform(5);
        for (int i = 0; i < cur_size; i++)
            write_sample(i, $random(seed) % 4096);
        for (int i = 0; i < cur_size; i++) begin
            read_coef(i, value, waited);
            compare_coef(i, value);
        end
        finish_test("random_size32");

        start_transform(4);
        for (int i = 0; i < cur_size; i++)
            write_sample(i, $random(seed) % 8192);
        read_coef(cur_size - 1, value, waited);  // last coefficient is computed last
        assert (waited >= cur_size) else begin
            $display("read of the last coefficient stalled only %0d cycles", waited);
            test_errors++;
        end
        compare_coef(cur_size - 1, value);
        finish_test("early_read");

        start_transform(1);
        for (int i = 0; i < cur_size; i++)
            write_sample(i, $random(seed) % 16384);
        expect_zero_read(5);
        read_coef(0, value, waited);
        // a stored entry answers after one stall cycle, a cleared one waits for the engine
        assert (waited > 1) else begin
            $display("coefficient 0 came back before the new transform stored it");
            test_errors++;
        end
        compare_coef(0, value);
        read_coef(1, value, waited);
        compare_coef(1, value);
        finish_test("restart_size2");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
